//--- compile.f
+incdir+src
src/rob_pkg.sv
src/cbuf.sv
src/phys_free_list.sv
src/rob.sv
src/rename_retire_top.sv
verif/rob_tb.sv

//--- Bender.yml
package:
  name: rob_rename

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rob_pkg.sv
      - src/cbuf.sv
      - src/phys_free_list.sv
      - src/rob.sv
      - src/rename_retire_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - verif/rob_tb.sv

//--- verif/rob_tb.sv
// Testbench for rename_retire_top with reference queue model, assertions and timeout
`timescale 1ns/10ps

`include "rob_settings.svh"

module rob_tb;

    import rob_pkg::*;

    // Phase lengths
    localparam int FULL_HOLD     = 8;
    localparam int STREAM_CYCLES = 1500;
    // Reset, fill, full ROB, retire, drain and refill stay below about 300 cycles
    // Streaming adds 1500, so the limit is about twice the expected run
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int FIRST_FREE     = `PREG_COUNT - `FREE_DEPTH;

    // Model entry, tag handed out plus the record expected at commit
    typedef struct packed {
        rob_tag_t   tag;
        rob_entry_t ent;
    } model_entry_t;

    logic      clk_i;
    logic      reset_i;
    logic      dispatch_valid_i;
    dispatch_t dispatch_i;
    logic      alloc_ready_o;
    rob_tag_t  alloc_tag_o;
    preg_t     alloc_prd_o;
    logic      update_valid_i;
    rob_tag_t  update_tag_i;
    logic      commit_valid_o;
    commit_t   commit_o;

    integer seed;
    int     error_cnt;
    int     check_cnt;
    int     cycle_cnt;

    // Reference model state
    model_entry_t          model_q[$];
    preg_t                 free_q[$];
    logic [`ROB_DEPTH-1:0] done_q;
    int                    fill_cnt;
    rob_tag_t              exp_tag;
    bit                    model_live;

    rename_retire_top i_dut (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_i       (dispatch_i),
        .alloc_ready_o    (alloc_ready_o),
        .alloc_tag_o      (alloc_tag_o),
        .alloc_prd_o      (alloc_prd_o),
        .update_valid_i   (update_valid_i),
        .update_tag_i     (update_tag_i),
        .commit_valid_o   (commit_valid_o),
        .commit_o         (commit_o)
    );

    // 4 ns period
    always #2 clk_i = ~clk_i;

    task automatic flag_error(input string msg);
        error_cnt++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    // New random instruction, accepted only if ready at the edge
    task automatic drive_dispatch(input bit valid);
        dispatch_t d;
        d.pc      = $random(seed);
        d.inst    = $random(seed);
        d.lrd     = lreg_t'($random(seed));
        d.old_prd = preg_t'($random(seed));
        dispatch_valid_i <= valid;
        dispatch_i       <= d;
    endtask

    // Complete a random live entry that has no result yet
    task automatic drive_update(input int pct);
        rob_tag_t cands[$];
        foreach (model_q[i]) begin
            if (!done_q[model_q[i].tag]) begin
                cands.push_back(model_q[i].tag);
            end
        end
        if ((cands.size() != 0) && (rand_below(100) < pct)) begin
            update_valid_i <= 1'b1;
            update_tag_i   <= cands[rand_below(cands.size())];
        end else begin
            update_valid_i <= 1'b0;
        end
    endtask

    // Outputs are stable at the falling edge, inputs seen here act at the next rise
    always @(negedge clk_i) begin : monitor
        logic         exp_ready;
        logic         exp_commit;
        logic         do_alloc;
        model_entry_t fresh;
        model_entry_t head;
        int           i;
        exp_ready  = (fill_cnt == `FREE_DEPTH) && (model_q.size() < `ROB_DEPTH) &&
                     (free_q.size() != 0);
        exp_commit = (model_q.size() != 0) && done_q[model_q[0].tag];
        do_alloc   = exp_ready && dispatch_valid_i && !reset_i;
        if (model_live) begin
            check_cnt += 2;
            assert (alloc_ready_o === exp_ready) else
                flag_error($sformatf("alloc_ready_o is %b, expected %b",
                                     alloc_ready_o, exp_ready));
            // Only a completed head may retire
            assert (commit_valid_o === exp_commit) else
                flag_error($sformatf("commit_valid_o is %b, expected %b",
                                     commit_valid_o, exp_commit));
            if (do_alloc) begin
                check_cnt += 2;
                assert (alloc_tag_o === exp_tag) else
                    flag_error($sformatf("alloc_tag_o is %0d, expected %0d",
                                         alloc_tag_o, exp_tag));
                // Fresh and recycled registers in free list order
                assert (alloc_prd_o === free_q[0]) else
                    flag_error($sformatf("alloc_prd_o is %0d, expected %0d",
                                         alloc_prd_o, free_q[0]));
            end
            if (exp_commit) begin
                check_cnt++;
                assert ((commit_o.pc === model_q[0].ent.pc) &&
                        (commit_o.inst === model_q[0].ent.inst) &&
                        (commit_o.lrd === model_q[0].ent.lrd) &&
                        (commit_o.old_prd === model_q[0].ent.old_prd) &&
                        (commit_o.prd === model_q[0].ent.prd)) else
                    flag_error($sformatf(
                        "commit tag %0d pc %h prd %0d old %0d, expected pc %h prd %0d old %0d",
                        model_q[0].tag, commit_o.pc, commit_o.prd,
                        commit_o.old_prd, model_q[0].ent.pc,
                        model_q[0].ent.prd, model_q[0].ent.old_prd));
            end
        end
        // Advance the model to the state after the next rising edge
        if (reset_i) begin
            model_q.delete();
            free_q.delete();
            for (i = 0; i < `FREE_DEPTH; i++) begin
                free_q.push_back(preg_t'(FIRST_FREE + i));
            end
            done_q     = '0;
            fill_cnt   = 0;
            exp_tag    = '0;
            model_live = 1'b1;
        end else if (model_live) begin
            if (fill_cnt < `FREE_DEPTH) begin
                fill_cnt++;
            end
            if (do_alloc) begin
                fresh.tag         = exp_tag;
                fresh.ent.pc      = dispatch_i.pc;
                fresh.ent.inst    = dispatch_i.inst;
                fresh.ent.lrd     = dispatch_i.lrd;
                fresh.ent.old_prd = dispatch_i.old_prd;
                fresh.ent.prd     = free_q.pop_front();
                done_q[exp_tag]   = 1'b0;
                model_q.push_back(fresh);
                exp_tag = exp_tag + 1'b1;
            end
            if (exp_commit) begin
                head = model_q.pop_front();
                // Old mapping joins the tail of the free list
                free_q.push_back(head.ent.old_prd);
            end
            if (update_valid_i) begin
                done_q[update_tag_i] = 1'b1;
            end
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        seed             = 32'h53226453;
        error_cnt        = 0;
        check_cnt        = 0;
        cycle_cnt        = 0;
        clk_i            = 1'b0;
        reset_i          = 1'b1;
        dispatch_valid_i = 1'b0;
        dispatch_i       = '0;
        update_valid_i   = 1'b0;
        update_tag_i     = '0;
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;

        // Strobes during the fill are dropped, then the ROB fills up
        while (model_q.size() < `ROB_DEPTH) begin
            @(posedge clk_i);
            drive_dispatch(1'b1);
            drive_update(0);
        end

        // Full ROB, strobes must not reach commit
        repeat (FULL_HOLD) begin
            @(posedge clk_i);
            drive_dispatch(1'b1);
        end

        // Random completion order, retirement in order
        while (model_q.size() != 0) begin
            @(posedge clk_i);
            drive_dispatch(1'b0);
            drive_update(100);
        end

        // Allocation, update and commit overlapping
        repeat (STREAM_CYCLES) begin
            @(posedge clk_i);
            drive_dispatch(rand_below(4) != 0);
            drive_update(60);
        end

        // Drain whatever is left
        while (model_q.size() != 0) begin
            @(posedge clk_i);
            drive_dispatch(1'b0);
            drive_update(100);
        end

        // Refill the whole ROB, every rename register has to come out again
        while (model_q.size() < `ROB_DEPTH) begin
            @(posedge clk_i);
            drive_dispatch(1'b1);
            drive_update(0);
        end
        @(posedge clk_i);
        drive_dispatch(1'b0);
        repeat (4) @(posedge clk_i);

        $display("Checks: %0d, errors: %0d, cycles: %0d", check_cnt, error_cnt, cycle_cnt);
        if (error_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src/rename_retire_top.sv
// Top level joining the ROB and the physical register free list
`timescale 1ns/10ps

module rename_retire_top (
    input  logic               clk_i,
    input  logic               reset_i,
    // Dispatch
    input  logic               dispatch_valid_i,
    input  rob_pkg::dispatch_t dispatch_i,
    output logic               alloc_ready_o,
    output rob_pkg::rob_tag_t  alloc_tag_o,
    output rob_pkg::preg_t     alloc_prd_o,
    // Execution completion
    input  logic               update_valid_i,
    input  rob_pkg::rob_tag_t  update_tag_i,
    // Retirement
    output logic               commit_valid_o,
    output rob_pkg::commit_t   commit_o
);

    logic rob_space;
    logic free_avail;
    logic alloc_fire;

    // Needs a ROB slot and a free register
    assign alloc_ready_o = rob_space & free_avail;
    // Strobes while not ready are dropped
    assign alloc_fire    = dispatch_valid_i & alloc_ready_o;

    rob i_rob (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .alloc_i        (alloc_fire),
        .alloc_data_i   (dispatch_i),
        .alloc_prd_i    (alloc_prd_o),
        .alloc_tag_o    (alloc_tag_o),
        .space_o        (rob_space),
        .update_i       (update_valid_i),
        .update_tag_i   (update_tag_i),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    // Retired old mapping goes back to the free list
    phys_free_list i_free_list (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .alloc_i       (alloc_fire),
        .alloc_prd_o   (alloc_prd_o),
        .release_i     (commit_valid_o),
        .release_prd_i (commit_o.old_prd),
        .avail_o       (free_avail)
    );

endmodule

//--- src/rob.sv
// Reorder buffer with cbuf entry storage, per-slot busy bits, completion and in-order commit
`timescale 1ns/10ps

`include "rob_settings.svh"

module rob (
    input  logic              clk_i,
    input  logic              reset_i,
    // Dispatch side
    input  logic              alloc_i,
    input  rob_pkg::dispatch_t alloc_data_i,
    input  rob_pkg::preg_t    alloc_prd_i,
    output rob_pkg::rob_tag_t alloc_tag_o,
    output logic              space_o,
    // Completion from execution
    input  logic              update_i,
    input  rob_pkg::rob_tag_t update_tag_i,
    // Retirement
    output logic              commit_valid_o,
    output rob_pkg::commit_t  commit_o
);

    import rob_pkg::*;

    rob_entry_t new_entry;
    rob_entry_t head_entry;
    rob_tag_t   head_tag;
    rob_tag_t   tail_tag;
    logic       empty;
    logic       full;
    logic       pop;

    // One busy bit per slot, set at allocation, cleared by the update
    logic [`ROB_DEPTH-1:0] busy_q;

    // Assemble stored entry from dispatch fields and the fresh prd
    always_comb begin
        new_entry.pc      = alloc_data_i.pc;
        new_entry.inst    = alloc_data_i.inst;
        new_entry.lrd     = alloc_data_i.lrd;
        new_entry.old_prd = alloc_data_i.old_prd;
        new_entry.prd     = alloc_prd_i;
    end

    // Tag is the slot index at the tail
    assign alloc_tag_o = tail_tag;
    assign space_o     = ~full;

    cbuf #(
        .DEPTH     (`ROB_DEPTH),
        .PAYLOAD_T (rob_entry_t)
    ) i_entry_buf (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (alloc_i),
        .push_data_i (new_entry),
        .pop_i       (pop),
        .head_data_o (head_entry),
        .head_idx_o  (head_tag),
        .tail_idx_o  (tail_tag),
        .empty_o     (empty),
        .full_o      (full)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= '0;
        end else begin
            // Completion
            if (update_i) begin
                busy_q[update_tag_i] <= 1'b0;
            end
            // New entry waits for its result
            if (alloc_i) begin
                busy_q[tail_tag] <= 1'b1;
            end
        end
    end

    // Head retires once its result is back
    assign commit_valid_o = ~empty & ~busy_q[head_tag];

    // No stall from the consumer, retire pops on the same edge
    assign pop = commit_valid_o;

    always_comb begin
        commit_o.pc      = head_entry.pc;
        commit_o.inst    = head_entry.inst;
        commit_o.lrd     = head_entry.lrd;
        commit_o.old_prd = head_entry.old_prd;
        commit_o.prd     = head_entry.prd;
    end

endmodule

//--- src/phys_free_list.sv
// Physical register free list on a cbuf, with post-reset fill and retired register recycling
`timescale 1ns/10ps

`include "rob_settings.svh"

module phys_free_list (
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           alloc_i,
    output rob_pkg::preg_t alloc_prd_o,
    input  logic           release_i,
    input  rob_pkg::preg_t release_prd_i,
    output logic           avail_o
);

    import rob_pkg::*;

    // First rename register, all below are architectural at reset
    localparam int FIRST_FREE = `PREG_COUNT - `FREE_DEPTH;
    localparam int FILL_W     = $clog2(`FREE_DEPTH) + 1;

    logic [FILL_W-1:0] fill_cnt_q;
    logic              filling;
    preg_t             fill_prd;

    logic  push;
    preg_t push_prd;
    logic  pop;
    logic  empty;

    // Fill runs for FREE_DEPTH cycles after reset
    assign filling  = (fill_cnt_q != FILL_W'(`FREE_DEPTH));
    assign fill_prd = preg_t'(FIRST_FREE) + preg_t'(fill_cnt_q);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fill_cnt_q <= '0;
        end else if (filling) begin
            fill_cnt_q <= fill_cnt_q + 1'b1;
        end
    end

    // Fill owns the push port, no release can arrive before the first alloc
    assign push     = filling | release_i;
    assign push_prd = filling ? fill_prd : release_prd_i;

    // Nothing handed out until the fill is over
    assign avail_o = ~filling & ~empty;
    assign pop     = alloc_i & avail_o;

    cbuf #(
        .DEPTH     (`FREE_DEPTH),
        .PAYLOAD_T (preg_t)
    ) i_free_buf (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (push),
        .push_data_i (push_prd),
        .pop_i       (pop),
        .head_data_o (alloc_prd_o),
        .head_idx_o  (),
        .tail_idx_o  (),
        .empty_o     (empty),
        .full_o      ()
    );

endmodule

//--- src/cbuf.sv
// Generic circular buffer with payload type parameter, wrap-bit pointers and status flags
`timescale 1ns/10ps

module cbuf #(
    parameter int  DEPTH     = 32,
    parameter type PAYLOAD_T = logic [7:0]
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     push_i,
    input  PAYLOAD_T                 push_data_i,
    input  logic                     pop_i,
    output PAYLOAD_T                 head_data_o,
    output logic [$clog2(DEPTH)-1:0] head_idx_o,
    output logic [$clog2(DEPTH)-1:0] tail_idx_o,
    output logic                     empty_o,
    output logic                     full_o
);

    localparam int IDX_W = $clog2(DEPTH);

    // Storage, no reset on payload
    PAYLOAD_T mem [DEPTH];

    // Pointers with one extra wrap bit on top
    logic [IDX_W:0] head_q;
    logic [IDX_W:0] tail_q;

    logic do_push;
    logic do_pop;

    assign head_idx_o = head_q[IDX_W-1:0];
    assign tail_idx_o = tail_q[IDX_W-1:0];

    // Same index, wrap bits decide between empty and full
    assign empty_o = (head_q == tail_q);
    assign full_o  = (head_q[IDX_W] != tail_q[IDX_W]) &&
                     (head_q[IDX_W-1:0] == tail_q[IDX_W-1:0]);

    // Pop from empty is dropped
    assign do_pop  = pop_i & ~empty_o;
    // Push into a full buffer only when the head leaves in the same cycle
    assign do_push = push_i & (~full_o | do_pop);

    // Head slot read straight from the array
    assign head_data_o = mem[head_idx_o];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (do_push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (do_pop) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    // Write at tail
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[tail_idx_o] <= push_data_i;
        end
    end

endmodule

//--- src/rob_pkg.sv
// Package with tag and register index types plus dispatch, entry and commit structs
package rob_pkg;

    `include "rob_settings.svh"

    // Index types
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [`LREG_W-1:0]    lreg_t;
    typedef logic [`PREG_W-1:0]    preg_t;

    // Sent by dispatch, 75 bits
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
        lreg_t            lrd;
        // Mapping of lrd before this instruction
        preg_t            old_prd;
    } dispatch_t;

    // One ROB slot, dispatch fields plus the fresh prd, 81 bits
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
        lreg_t            lrd;
        preg_t            old_prd;
        preg_t            prd;
    } rob_entry_t;

    // Retired record on the commit port
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
        lreg_t            lrd;
        preg_t            old_prd;
        preg_t            prd;
    } commit_t;

endpackage

//--- src/rob_settings.svh
// Size macros for the ROB, logical and physical register files and data words
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// ROB slots and tag width, depth must stay a power of two
`define ROB_DEPTH 32
`define ROB_TAG_W 5

// Architectural register index
`define LREG_W 5

// Physical register file, 32 architectural plus 32 rename registers
`define PREG_COUNT 64
`define PREG_W 6

// Rename registers free at reset
`define FREE_DEPTH 32

// PC and instruction word
`define XLEN 32

`endif
